// File: rv32i_types.sv
`default_nettype none

package rv32i_types;

    // major opcodes of the three decoded formats
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // register-register alu
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    // register-immediate alu, 12-bit signed immediate
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    // conditional branch, offset bits scattered over the word
    typedef struct packed {
        logic        imm12;
        logic [5:0]  imm10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        opcode_e     opcode;
    } b_fmt_t;

    // one instruction word, view picked by the opcode
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
    } instr_u;

endpackage : rv32i_types

`default_nettype wire

// File: tomasula_types.sv
`default_nettype none

package tomasula_types;

    // rob tag width, room for up to 16 entries
    localparam int ROB_TAG_W = 4;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // instruction class, picks the station type
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        BRANCH = 2'd1
    } op_e;

    // decoded instruction as held in the queue
    typedef struct packed {
        op_e         op;
        // {funct7[5], funct3}
        logic [3:0]  alu_fn;
        logic [4:0]  dest_reg;
        logic [4:0]  src1_reg;
        logic [4:0]  src2_reg;
        // second operand from imm instead of src2
        logic        use_imm;
        // already sign-extended
        logic [31:0] imm;
    } ctl_word;

    // one bit per reservation station, alu1 in bit 0
    typedef struct packed {
        logic br;
        logic alu4;
        logic alu3;
        logic alu2;
        logic alu1;
    } rs_sel_t;

    // what leaves the issue stage with a station load
    typedef struct packed {
        ctl_word  ctl;
        rob_tag_t tag;
    } dispatch_t;

endpackage : tomasula_types

`default_nettype wire

// File: fifo_synch_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_synch_1r1w #(
    parameter type DTYPE = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  wire  clk_i,
    input  wire  reset_n_i,
    input  DTYPE data_i,
    input  logic valid_i,
    output logic ready_o,
    output logic valid_o,
    output DTYPE data_o,
    input  logic yumi_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DTYPE             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // wrap explicitly so non power of two depths work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push    = valid_i & ready_o;
    assign pop     = yumi_i & valid_o;
    assign ready_o = (count_q != CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    // head shown straight from storage, first word fall through
    assign data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage itself
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    // producer must respect ready
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        valid_i |-> ready_o);

    // consumer only takes a valid head
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        yumi_i |-> valid_o);

endmodule : fifo_synch_1r1w

`default_nettype wire

// File: ir_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ir_decoder (
    input  wire                     clk,
    input  wire                     rst_i,
    input  logic                    inst_valid_i,
    input  rv32i_types::instr_u     inst_i,
    input  logic                    ack_i,
    output logic                    ld_iq_o,
    output tomasula_types::ctl_word control_word_o,
    output logic                    busy_o,
    output logic                    illegal_o
);

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        ISSUE
    } state_e;

    state_e                  state_q;
    rv32i_types::instr_u     inst_q;
    tomasula_types::ctl_word dec_word;
    logic                    dec_legal;

    // decode from the captured word, view chosen by opcode
    always_comb begin
        dec_word  = '0;
        dec_legal = 1'b1;
        case (inst_q.r.opcode)
            rv32i_types::OP_REG: begin
                dec_word.op       = tomasula_types::ALU;
                dec_word.alu_fn   = {inst_q.r.funct7[5], inst_q.r.funct3};
                dec_word.dest_reg = inst_q.r.rd;
                dec_word.src1_reg = inst_q.r.rs1;
                dec_word.src2_reg = inst_q.r.rs2;
            end
            rv32i_types::OP_IMM: begin
                dec_word.op       = tomasula_types::ALU;
                // bit 30 only matters for srai vs srli
                dec_word.alu_fn   = {(inst_q.i.funct3 == 3'b101) & inst_q.i.imm[10],
                                     inst_q.i.funct3};
                dec_word.dest_reg = inst_q.i.rd;
                dec_word.src1_reg = inst_q.i.rs1;
                dec_word.use_imm  = 1'b1;
                dec_word.imm      = {{20{inst_q.i.imm[11]}}, inst_q.i.imm};
            end
            rv32i_types::OP_BRANCH: begin
                dec_word.op       = tomasula_types::BRANCH;
                dec_word.alu_fn   = {1'b0, inst_q.b.funct3};
                dec_word.src1_reg = inst_q.b.rs1;
                dec_word.src2_reg = inst_q.b.rs2;
                // compare uses rs2, imm is the branch offset
                dec_word.imm      = {{19{inst_q.b.imm12}}, inst_q.b.imm12, inst_q.b.imm11,
                                     inst_q.b.imm10_5, inst_q.b.imm4_1, 1'b0};
            end
            default: begin
                dec_legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= IDLE;
            illegal_o <= 1'b0;
        end else begin
            illegal_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (inst_valid_i) begin
                        state_q <= DECODE;
                    end
                end
                DECODE: begin
                    // illegal words are dropped here
                    if (dec_legal) begin
                        state_q <= ISSUE;
                    end else begin
                        state_q   <= IDLE;
                        illegal_o <= 1'b1;
                    end
                end
                ISSUE: begin
                    if (ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // instruction and decoded word
    always_ff @(posedge clk) begin
        if (state_q == IDLE && inst_valid_i) begin
            inst_q <= inst_i;
        end
        if (state_q == DECODE) begin
            control_word_o <= dec_word;
        end
    end

    assign ld_iq_o = (state_q == ISSUE);
    assign busy_o  = (state_q != IDLE);

    // request held with a steady word until the queue takes it
    a_hold_req: assert property (@(posedge clk) disable iff (rst_i)
        ld_iq_o && !ack_i |=> ld_iq_o && $stable(control_word_o));

endmodule : ir_decoder

`default_nettype wire

// File: iq.sv
`timescale 1ns/1ps
`default_nettype none

module iq #(
    parameter int IQ_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst_i,
    input  logic                    ld_iq_i,
    input  tomasula_types::ctl_word control_word_i,
    output logic                    ack_o,
    input  tomasula_types::rs_sel_t rs_empty_i,
    input  logic                    rob_full_i,
    output tomasula_types::rs_sel_t rs_load_o,
    output logic                    rob_load_o,
    output tomasula_types::ctl_word control_o
);

    logic                    fifo_ready;
    logic                    head_valid;
    logic                    enqueue;
    logic                    dequeue;
    tomasula_types::ctl_word head;

    fifo_synch_1r1w #(
        .DTYPE (tomasula_types::ctl_word),
        .DEPTH (IQ_DEPTH)
    ) u_fifo (
        .clk_i     (clk),
        .reset_n_i (~rst_i),
        .data_i    (control_word_i),
        .valid_i   (enqueue),
        .ready_o   (fifo_ready),
        .valid_o   (head_valid),
        .data_o    (head),
        .yumi_i    (dequeue)
    );

    // ack in the same cycle whenever there is space
    assign ack_o   = fifo_ready;
    assign enqueue = ld_iq_i & fifo_ready;

    // head goes out in order, never past a stalled entry
    always_comb begin
        rs_load_o = '0;
        if (head_valid && !rob_full_i) begin
            if (head.op == tomasula_types::BRANCH) begin
                rs_load_o.br = rs_empty_i.br;
            end else if (rs_empty_i.alu1) begin
                rs_load_o.alu1 = 1'b1;
            end else if (rs_empty_i.alu2) begin
                rs_load_o.alu2 = 1'b1;
            end else if (rs_empty_i.alu3) begin
                rs_load_o.alu3 = 1'b1;
            end else if (rs_empty_i.alu4) begin
                rs_load_o.alu4 = 1'b1;
            end
        end
    end

    // any station load pops the head and takes a rob slot
    assign dequeue    = |rs_load_o;
    assign rob_load_o = dequeue;
    assign control_o  = head;

    // single target per dispatch, rob allocated with it
    a_one_target: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(rs_load_o) && (rob_load_o == (rs_load_o != '0)));

endmodule : iq

`default_nettype wire

// File: rob_counter.sv
`timescale 1ns/1ps
`default_nettype none

module rob_counter #(
    parameter int ROB_DEPTH = 8
) (
    input  wire                      clk,
    input  wire                      rst_i,
    input  logic                     rob_load_i,
    input  logic                     commit_i,
    output logic                     rob_full_o,
    output tomasula_types::rob_tag_t rob_tag_o
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic [CNT_W-1:0]         count_q;
    tomasula_types::rob_tag_t tag_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q <= '0;
            tag_q   <= '0;
        end else begin
            // load and commit together cancel out
            case ({rob_load_i, commit_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // tail tag wraps at the rob depth
            if (rob_load_i) begin
                if (tag_q == tomasula_types::ROB_TAG_W'(ROB_DEPTH - 1)) begin
                    tag_q <= '0;
                end else begin
                    tag_q <= tag_q + 1'b1;
                end
            end
        end
    end

    assign rob_full_o = (count_q == CNT_W'(ROB_DEPTH));
    // tag of the entry the next load takes
    assign rob_tag_o  = tag_q;

    // the queue must stall on a full rob
    a_no_load_full: assert property (@(posedge clk) disable iff (rst_i)
        rob_load_i |-> !rob_full_o);

    // commits only retire existing entries
    a_no_commit_empty: assert property (@(posedge clk) disable iff (rst_i)
        commit_i |-> (count_q != '0));

endmodule : rob_counter

`default_nettype wire

// File: rs_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module rs_tracker (
    input  wire                     clk,
    input  wire                     rst_i,
    input  tomasula_types::rs_sel_t rs_load_i,
    input  tomasula_types::rs_sel_t rs_done_i,
    output tomasula_types::rs_sel_t rs_empty_o
);

    // one busy bit per station, same order as rs_sel_t
    logic [4:0] busy_q;
    logic [4:0] load;
    logic [4:0] done;

    assign load = rs_load_i;
    assign done = rs_done_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= '0;
        end else begin
            // done on an idle station clears nothing
            // a new load wins over a stray done
            busy_q <= (busy_q & ~done) | load;
        end
    end

    assign rs_empty_o = tomasula_types::rs_sel_t'(~busy_q);

    // dispatch only targets a free station
    a_load_free: assert property (@(posedge clk) disable iff (rst_i)
        (load & busy_q) == '0);

endmodule : rs_tracker

`default_nettype wire

// File: issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_top #(
    parameter int IQ_DEPTH  = 4,
    parameter int ROB_DEPTH = 8
) (
    input  wire                       clk,
    input  wire                       rst_i,
    input  logic                      inst_valid_i,
    input  rv32i_types::instr_u       inst_i,
    input  tomasula_types::rs_sel_t   rs_done_i,
    input  logic                      commit_i,
    output logic                      busy_o,
    output logic                      illegal_o,
    output tomasula_types::rs_sel_t   rs_load_o,
    output tomasula_types::dispatch_t dispatch_o
);

    // decoder to queue
    logic                     ld_iq;
    logic                     ack;
    tomasula_types::ctl_word  control_word;

    // queue to tracker and counter
    tomasula_types::rs_sel_t  rs_empty;
    logic                     rob_full;
    logic                     rob_load;
    tomasula_types::ctl_word  head_word;
    tomasula_types::rob_tag_t rob_tag;

    ir_decoder u_decoder (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .ack_i          (ack),
        .ld_iq_o        (ld_iq),
        .control_word_o (control_word),
        .busy_o         (busy_o),
        .illegal_o      (illegal_o)
    );

    iq #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_iq (
        .clk            (clk),
        .rst_i          (rst_i),
        .ld_iq_i        (ld_iq),
        .control_word_i (control_word),
        .ack_o          (ack),
        .rs_empty_i     (rs_empty),
        .rob_full_i     (rob_full),
        .rs_load_o      (rs_load_o),
        .rob_load_o     (rob_load),
        .control_o      (head_word)
    );

    rob_counter #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk        (clk),
        .rst_i      (rst_i),
        .rob_load_i (rob_load),
        .commit_i   (commit_i),
        .rob_full_o (rob_full),
        .rob_tag_o  (rob_tag)
    );

    rs_tracker u_rs (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs_load_i  (rs_load_o),
        .rs_done_i  (rs_done_i),
        .rs_empty_o (rs_empty)
    );

    // head word tagged with the rob tail, valid with a station load
    assign dispatch_o = '{ctl: head_word, tag: rob_tag};

endmodule : issue_top

`default_nettype wire

// File: tb_issue_table.svh
// each row gives name, instruction, strobe, rs_done, commit, illegal and expected ctl word
task automatic fill_table();
    tomasula_types::ctl_word none;
    none = '0;
    // fill all four alu stations and the branch station
    add_row("add", enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1), 1, 5'b00000, 0, 0,
            mk_ctl(tomasula_types::ALU, 4'b0000, 5'd1, 5'd2, 5'd3, 1'b0, 32'h0));
    add_row("sub", enc_r(7'h20, 5'd6, 5'd5, 3'b000, 5'd4), 1, 5'b00000, 0, 0,
            mk_ctl(tomasula_types::ALU, 4'b1000, 5'd4, 5'd5, 5'd6, 1'b0, 32'h0));
    add_row("addi_neg", enc_i(12'hffb, 5'd8, 3'b000, 5'd7), 1, 5'b00000, 0, 0,
            mk_ctl(tomasula_types::ALU, 4'b0000, 5'd7, 5'd8, 5'd0, 1'b1, 32'hffff_fffb));
    add_row("srai", enc_i(12'h403, 5'd10, 3'b101, 5'd9), 1, 5'b00000, 0, 0,
            mk_ctl(tomasula_types::ALU, 4'b1101, 5'd9, 5'd10, 5'd0, 1'b1, 32'h0000_0403));
    add_row("beq_neg", enc_b(13'h1ff0, 5'd2, 5'd1, 3'b000), 1, 5'b00000, 0, 0,
            mk_ctl(tomasula_types::BRANCH, 4'b0000, 5'd0, 5'd1, 5'd2, 1'b0, 32'hffff_fff0));
    // branch station freed while the alu word stalls
    add_row("xori_stall", enc_i(12'h7ff, 5'd12, 3'b100, 5'd11), 1, 5'b10000, 0, 0,
            mk_ctl(tomasula_types::ALU, 4'b0100, 5'd11, 5'd12, 5'd0, 1'b1, 32'h0000_07ff));
    // free br yet the branch waits behind the stalled alu word
    add_row("bne_wait", enc_b(13'h0008, 5'd4, 5'd3, 3'b001), 1, 5'b00000, 0, 0,
            mk_ctl(tomasula_types::BRANCH, 4'b0001, 5'd0, 5'd3, 5'd4, 1'b0, 32'h0000_0008));
    add_row("free_alu2", 32'h0, 0, 5'b00010, 0, 0, none);
    add_row("free_br", 32'h0, 0, 5'b10000, 0, 0, none);
    // eighth dispatch fills the rob
    add_row("or_rob_fill", enc_r(7'h00, 5'd15, 5'd14, 3'b110, 5'd13), 1, 5'b00001, 0, 0,
            mk_ctl(tomasula_types::ALU, 4'b0110, 5'd13, 5'd14, 5'd15, 1'b0, 32'h0));
    // load and store are outside the decoded set
    add_row("lw_illegal", 32'h0001_2083, 1, 5'b00000, 0, 1, none);
    add_row("sw_illegal", 32'h0020_a023, 1, 5'b00000, 0, 1, none);
    // stations freed while the rob is full
    add_row("and_rob_stall", enc_r(7'h00, 5'd18, 5'd17, 3'b111, 5'd16), 1, 5'b01100, 0, 0,
            mk_ctl(tomasula_types::ALU, 4'b0111, 5'd16, 5'd17, 5'd18, 1'b0, 32'h0));
    add_row("slti_rob_stall", enc_i(12'hfff, 5'd20, 3'b010, 5'd19), 1, 5'b00000, 0, 0,
            mk_ctl(tomasula_types::ALU, 4'b0010, 5'd19, 5'd20, 5'd0, 1'b1, 32'hffff_ffff));
    // each commit lets one more word dispatch
    add_row("commit_one", 32'h0, 0, 5'b00000, 1, 0, none);
    add_row("commit_two", 32'h0, 0, 5'b00000, 1, 0, none);
endtask

// File: tb_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue;

    localparam int IQ_DEPTH    = 4;
    localparam int ROB_DEPTH   = 8;
    localparam int IDLE_CYCLES = 6;

    // one step of the table
    typedef struct {
        string                   name;
        logic [31:0]             instr;
        bit                      strobe;
        logic [4:0]              done;
        bit                      commit;
        bit                      illegal;
        tomasula_types::ctl_word exp;
    } row_t;

    logic                      clk;
    logic                      rst_i;
    logic                      inst_valid_i;
    rv32i_types::instr_u       inst_i;
    tomasula_types::rs_sel_t   rs_done_i;
    logic                      commit_i;
    logic                      busy_o;
    logic                      illegal_o;
    tomasula_types::rs_sel_t   rs_load_o;
    tomasula_types::dispatch_t dispatch_o;

    row_t                    rows[$];
    tomasula_types::ctl_word exp_q[$];
    // reference model of stations and rob
    logic [4:0]              m_busy;
    int                      m_count;
    int                      m_tag;
    int                      mismatch_cnt;
    int                      other_cnt;
    integer                  seed;
    string                   cur_name;
    bit                      table_ready;

    issue_top #(
        .IQ_DEPTH  (IQ_DEPTH),
        .ROB_DEPTH (ROB_DEPTH)
    ) UUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs_done_i    (rs_done_i),
        .commit_i     (commit_i),
        .busy_o       (busy_o),
        .illegal_o    (illegal_o),
        .rs_load_o    (rs_load_o),
        .dispatch_o   (dispatch_o)
    );

    always #10 clk = ~clk;

    // instruction encoders, straight from the isa field layout
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // off is the 13-bit byte offset, bit 0 dropped
    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic tomasula_types::ctl_word mk_ctl(input tomasula_types::op_e op,
            input logic [3:0] fn, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic use_imm, input logic [31:0] imm);
        tomasula_types::ctl_word w;
        w.op       = op;
        w.alu_fn   = fn;
        w.dest_reg = rd;
        w.src1_reg = rs1;
        w.src2_reg = rs2;
        w.use_imm  = use_imm;
        w.imm      = imm;
        return w;
    endfunction

    task automatic add_row(input string name, input logic [31:0] instr, input bit strobe,
                           input logic [4:0] done, input bit commit, input bit illegal,
                           input tomasula_types::ctl_word exp);
        row_t r;
        r.name    = name;
        r.instr   = instr;
        r.strobe  = strobe;
        r.done    = done;
        r.commit  = commit;
        r.illegal = illegal;
        r.exp     = exp;
        rows.push_back(r);
    endtask

    `include "tb_issue_table.svh"

    // in order, rob room first, then lowest free alu or the branch station
    function automatic logic [4:0] expected_target(input tomasula_types::op_e op);
        if (m_count >= ROB_DEPTH) begin
            return 5'd0;
        end
        if (op == tomasula_types::BRANCH) begin
            return m_busy[4] ? 5'd0 : 5'b10000;
        end
        for (int k = 0; k < 4; k++) begin
            if (!m_busy[k]) begin
                return 5'(1 << k);
            end
        end
        return 5'd0;
    endfunction

    // check outputs at the falling edge, then drive the next inputs
    task automatic step(input logic valid, input logic [31:0] instr,
                        input logic [4:0] done, input logic commit);
        logic [4:0] load;
        logic [4:0] target;
        @(negedge clk);
        load = rs_load_o;
        assert ($onehot0(load)) else begin
            other_cnt++;
            $display("more than one station loaded at once during %s", cur_name);
        end
        if (load != 5'd0) begin
            if (exp_q.size() == 0) begin
                other_cnt++;
                $display("dispatch with no instruction pending during %s", cur_name);
            end else begin
                target = expected_target(exp_q[0].op);
                assert (load == target) else begin
                    mismatch_cnt++;
                    $display("mismatch %s station: expected %b actual %b",
                             cur_name, target, load);
                end
                assert (dispatch_o.ctl == exp_q[0]) else begin
                    mismatch_cnt++;
                    $display("mismatch %s ctl: expected %h actual %h",
                             cur_name, exp_q[0], dispatch_o.ctl);
                end
                assert (dispatch_o.tag == 4'(m_tag)) else begin
                    mismatch_cnt++;
                    $display("mismatch %s tag: expected %0d actual %0d",
                             cur_name, m_tag, dispatch_o.tag);
                end
                void'(exp_q.pop_front());
            end
            m_tag = (m_tag == ROB_DEPTH - 1) ? 0 : m_tag + 1;
            m_count++;
        end
        if (commit) begin
            m_count--;
        end
        m_busy       = (m_busy & ~done) | load;
        inst_valid_i = valid;
        inst_i       = instr;
        rs_done_i    = done;
        commit_i     = commit;
    endtask

    task automatic idle();
        step(1'b0, 32'd0, 5'd0, 1'b0);
    endtask

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((rows.size() + 4) * 40 * 20);
        $display("watchdog expired, the run did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        bit          seen;
        logic [31:0] r;
        clk          = 1'b0;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        rs_done_i    = '0;
        commit_i     = 1'b0;
        m_busy       = '0;
        m_count      = 0;
        m_tag        = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        seed         = 32'h532e;
        cur_name     = "reset";
        fill_table();
        table_ready  = 1'b1;
        repeat (2) @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        assert (rs_load_o == '0 && !busy_o && !illegal_o) else begin
            other_cnt++;
            $display("outputs not idle right after reset");
        end
        foreach (rows[i]) begin
            cur_name = rows[i].name;
            if (rows[i].strobe) begin
                // decoder ignores strobes while busy
                while (busy_o) begin
                    idle();
                end
                step(1'b1, rows[i].instr, rows[i].done, rows[i].commit);
                if (!rows[i].illegal) begin
                    exp_q.push_back(rows[i].exp);
                end
                seen = 1'b0;
                do begin
                    idle();
                    if (illegal_o) begin
                        seen = 1'b1;
                    end
                end while (busy_o);
                assert (seen == rows[i].illegal) else begin
                    mismatch_cnt++;
                    $display("mismatch %s illegal: expected %0d actual %0d",
                             cur_name, rows[i].illegal, seen);
                end
            end else begin
                step(1'b0, 32'd0, rows[i].done, rows[i].commit);
            end
            repeat (IDLE_CYCLES) begin
                idle();
            end
        end
        // random completions and commits on top
        cur_name = "drain";
        repeat (40) begin
            r = $random(seed);
            step(1'b0, 32'd0, r[4:0] & m_busy, r[8] && (m_count > 0));
        end
        repeat (4) begin
            idle();
        end
        assert (exp_q.size() == 0) else begin
            other_cnt++;
            $display("%0d instructions were never dispatched", exp_q.size());
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_issue

`default_nettype wire

// File: compile.f
+incdir+.
rv32i_types.sv
tomasula_types.sv
fifo_synch_1r1w.sv
ir_decoder.sv
iq.sv
rob_counter.sv
rs_tracker.sv
issue_top.sv
tb_issue.sv

// File: run.sh
#!/bin/sh
verilator --binary --assert -f compile.f --top-module tb_issue -o sim_issue \
    && ./obj_dir/sim_issue | tee /dev/stderr | grep -qF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
